//--- hdl/i2c_regs_pkg.sv
// i2c register target package
package i2c_regs_pkg;

    // 7-bit bus address, byte 0x50 with R/W clear
    localparam logic [6:0] target_addr = 7'h28;

    // equal samples before a line level is accepted
    localparam int debounce_len = 10;

    // number of read/write words
    localparam int word_count = 4;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] reg_ptr_t;
    typedef logic [2:0] host_addr_t;

    // register word, seen whole by the host
    // or as two bytes by the bus
    typedef union packed
    {
        logic [15:0] word;
        struct packed
        {
            byte_t hi;
            byte_t lo;
        } bytes;
    } reg_word_u;

    // first read-only pointer
    localparam reg_ptr_t ro_base = 8'h08;

    // read-only bytes at 0x08..0x0B
    localparam byte_t ro_values [word_count] = '{8'h10, 8'h20, 8'h30, 8'h40};

    // word values after reset
    localparam logic [15:0] word_reset [word_count] = '{16'h8095, 16'h031D, 16'h0000, 16'h0000};

    // returned for pointers past the map
    localparam byte_t bad_read_value = 8'hFF;

    // debounced line state and bus conditions
    typedef struct packed
    {
        logic       scl_rise;
        logic       scl_fall;
        logic       scl_high;
        logic       sda_level;
        logic       start;
        logic       stop;
        logic [1:0] start_count;
    } line_events_t;

    // register access request, 17 bits
    typedef struct packed
    {
        logic     write;
        reg_ptr_t ptr;
        byte_t    wdata;
    } reg_req_t;

endpackage

//--- hdl/bus_sampler.sv
// scl and sda line sampler
module bus_sampler
    import i2c_regs_pkg::*;
(
    input  logic         CLOCK,
    input  logic         RESET,
    input  logic         scl,
    input  logic         sda_in,
    output line_events_t events
);

    // older samples, the live input makes the last one
    logic [debounce_len-2:0] scl_pipe;
    logic [debounce_len-2:0] sda_pipe;
    logic                    scl_deb;
    logic                    scl_d;
    logic                    sda_deb;
    logic                    sda_d;
    logic                    scl_high;
    logic                    sda_rise;
    logic                    sda_fall;
    logic                    start_q;
    logic                    stop_q;
    logic [1:0]              start_cnt;

    // scl stable high over two samples
    assign scl_high = scl_deb & scl_d;
    assign sda_rise = sda_deb & ~sda_d;
    assign sda_fall = ~sda_deb & sda_d;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            // idle bus is high on both lines
            scl_pipe  <= '1;
            sda_pipe  <= '1;
            scl_deb   <= 1'b1;
            scl_d     <= 1'b1;
            sda_deb   <= 1'b1;
            sda_d     <= 1'b1;
            start_q   <= 1'b0;
            stop_q    <= 1'b0;
            start_cnt <= 2'd0;
        end
        else
        begin
            scl_pipe <= {scl_pipe[debounce_len-3:0], scl};
            sda_pipe <= {sda_pipe[debounce_len-3:0], sda_in};
            // level taken only when every sample agrees
            if (&{scl_pipe, scl})
                scl_deb <= 1'b1;
            else if (~|{scl_pipe, scl})
                scl_deb <= 1'b0;
            if (&{sda_pipe, sda_in})
                sda_deb <= 1'b1;
            else if (~|{sda_pipe, sda_in})
                sda_deb <= 1'b0;
            scl_d <= scl_deb;
            sda_d <= sda_deb;
            // start is sda falling with scl high
            start_q <= scl_high & sda_fall;
            // stop is sda rising with scl high
            stop_q  <= scl_high & sda_rise;
            // second start before a stop marks a repeated start
            if (scl_high & sda_rise)
                start_cnt <= 2'd0;
            else if ((scl_high & sda_fall) && (start_cnt != 2'd2))
                start_cnt <= start_cnt + 2'd1;
        end
    end

    always_comb
    begin
        events.scl_rise    = scl_deb & ~scl_d;
        events.scl_fall    = ~scl_deb & scl_d;
        events.scl_high    = scl_high;
        events.sda_level   = sda_deb;
        events.start       = start_q;
        events.stop        = stop_q;
        events.start_count = start_cnt;
    end

endmodule

//--- hdl/byte_shifter.sv
// i2c byte shift engine
module byte_shifter
    import i2c_regs_pkg::*;
(
    input  logic         CLOCK,
    input  logic         RESET,
    input  line_events_t events,
    input  logic         start_rx,
    input  logic         start_tx,
    input  byte_t        tx_byte,
    input  logic         nack_mode,
    output byte_t        rx_byte,
    output logic         byte_done,
    output logic         sda_pull
);

    typedef enum logic [2:0]
    {
        sh_idle,
        sh_rx,
        sh_ack_wait,
        sh_ack,
        sh_tx
    } sh_state_t;

    sh_state_t  state;
    logic [2:0] bit_cnt;
    // shared shift register for both directions
    byte_t      shreg;

    // received byte stays readable through the ack clock
    assign rx_byte = shreg;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state     <= sh_idle;
            bit_cnt   <= 3'd0;
            sda_pull  <= 1'b0;
            byte_done <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            // any start or stop aborts the byte and frees sda
            if (events.start || events.stop)
            begin
                state    <= sh_idle;
                sda_pull <= 1'b0;
            end
            else
            begin
                case (state)
                    sh_idle:
                    begin
                        bit_cnt <= 3'd0;
                        if (start_rx)
                        begin
                            state <= sh_rx;
                        end
                        else if (start_tx)
                        begin
                            // scl is low here, msb goes out at once
                            state    <= sh_tx;
                            shreg    <= tx_byte;
                            sda_pull <= ~tx_byte[7];
                        end
                    end
                    sh_rx:
                    begin
                        // msb first, sampled on scl rise
                        if (events.scl_rise)
                        begin
                            shreg   <= {shreg[6:0], events.sda_level};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                state <= sh_ack_wait;
                        end
                    end
                    sh_ack_wait:
                    begin
                        // ack driven from the fall after bit 0
                        if (events.scl_fall)
                        begin
                            sda_pull <= ~nack_mode;
                            state    <= sh_ack;
                        end
                    end
                    sh_ack:
                    begin
                        // ack clock over
                        if (events.scl_fall)
                        begin
                            sda_pull  <= 1'b0;
                            byte_done <= 1'b1;
                            state     <= sh_idle;
                        end
                    end
                    sh_tx:
                    begin
                        if (events.scl_fall)
                        begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                            begin
                                // master ack is not checked
                                sda_pull  <= 1'b0;
                                byte_done <= 1'b1;
                                state     <= sh_idle;
                            end
                            else
                            begin
                                sda_pull <= ~shreg[6];
                            end
                        end
                    end
                    default:
                    begin
                        state <= sh_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/transaction_ctrl.sv
// i2c transaction controller
module transaction_ctrl
    import i2c_regs_pkg::*;
(
    input  logic         CLOCK,
    input  logic         RESET,
    input  line_events_t events,
    output logic         start_rx,
    output logic         start_tx,
    output byte_t        tx_byte,
    output logic         nack_mode,
    input  byte_t        rx_byte,
    input  logic         byte_done,
    output logic         req_valid,
    output reg_req_t     req,
    input  logic         req_ack,
    input  byte_t        rd_byte
);

    typedef enum logic [2:0]
    {
        st_idle,
        st_ctrl,
        st_ptr,
        st_data,
        st_read,
        st_wait
    } ctrl_state_t;

    ctrl_state_t state;
    logic        addr_match;
    logic        rd_bit;
    logic        ctrl_bad;

    assign addr_match = (rx_byte[7:1] == target_addr);
    assign rd_bit     = rx_byte[0];
    // read control byte only valid after a repeated start
    assign ctrl_bad   = !addr_match || (rd_bit && (events.start_count != 2'd2));
    // shifter samples this at the fall after bit 0
    assign nack_mode  = (state == st_ctrl) && ctrl_bad;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            start_rx  <= 1'b0;
            start_tx  <= 1'b0;
            req_valid <= 1'b0;
            req       <= '0;
        end
        else
        begin
            start_rx <= 1'b0;
            start_tx <= 1'b0;
            if (events.stop)
            begin
                state     <= st_idle;
                req_valid <= 1'b0;
            end
            else if (events.start)
            begin
                // first or repeated start, control byte follows
                state     <= st_ctrl;
                start_rx  <= 1'b1;
                req_valid <= 1'b0;
            end
            else
            begin
                case (state)
                    st_ctrl:
                    begin
                        if (byte_done)
                        begin
                            if (ctrl_bad)
                            begin
                                state <= st_idle;
                            end
                            else if (rd_bit)
                            begin
                                // fetch the byte before sending it
                                req.write <= 1'b0;
                                req_valid <= 1'b1;
                                state     <= st_read;
                            end
                            else
                            begin
                                start_rx <= 1'b1;
                                state    <= st_ptr;
                            end
                        end
                    end
                    st_ptr:
                    begin
                        if (byte_done)
                        begin
                            req.ptr  <= rx_byte;
                            start_rx <= 1'b1;
                            state    <= st_data;
                        end
                    end
                    st_data:
                    begin
                        // data byte, or a repeated start taken above
                        if (byte_done)
                        begin
                            req.write <= 1'b1;
                            req.wdata <= rx_byte;
                            req_valid <= 1'b1;
                        end
                        else if (req_valid && req_ack)
                        begin
                            req_valid <= 1'b0;
                            state     <= st_wait;
                        end
                    end
                    st_read:
                    begin
                        if (req_valid && req_ack)
                        begin
                            req_valid <= 1'b0;
                            tx_byte   <= rd_byte;
                            start_tx  <= 1'b1;
                        end
                        else if (byte_done)
                        begin
                            state <= st_wait;
                        end
                    end
                    default:
                    begin
                        // idle and wait leave only on start or stop
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/reg_file.sv
// register map and host read port
module reg_file
    import i2c_regs_pkg::*;
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        req_valid,
    input  reg_req_t    req,
    output logic        req_ack,
    output byte_t       rd_byte,
    input  logic        rd_en,
    input  host_addr_t  host_addr,
    output logic [15:0] host_data
);

    reg_word_u  words [word_count];
    logic [1:0] word_sel;
    logic       in_rw;
    logic       in_ro;
    byte_t      rd_value;

    // two pointers per word, even is the high byte
    assign word_sel = req.ptr[2:1];
    assign in_rw    = (req.ptr < ro_base);
    assign in_ro    = (req.ptr >= ro_base) && (req.ptr < ro_base + 8'(word_count));

    always_comb
    begin
        if (in_rw)
            rd_value = req.ptr[0] ? words[word_sel].bytes.lo : words[word_sel].bytes.hi;
        else if (in_ro)
            rd_value = ro_values[req.ptr[1:0]];
        else
            rd_value = bad_read_value;
    end

    // access done when ack rises, ack falls after valid drops
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            req_ack <= 1'b0;
            for (int i = 0; i < word_count; i++)
                words[i].word <= word_reset[i];
        end
        else if (req_valid && !req_ack)
        begin
            req_ack <= 1'b1;
            rd_byte <= rd_value;
            // read-only and unmapped pointers drop writes
            if (req.write && in_rw)
            begin
                if (req.ptr[0])
                    words[word_sel].bytes.lo <= req.wdata;
                else
                    words[word_sel].bytes.hi <= req.wdata;
            end
        end
        else if (!req_valid)
        begin
            req_ack <= 1'b0;
        end
    end

    // host port holds between reads
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
            host_data <= '0;
        else if (rd_en)
            host_data <= (host_addr < host_addr_t'(word_count)) ? words[host_addr[1:0]].word : '0;
    end

endmodule

//--- hdl/i2c_regs_top.sv
// i2c register target top
module i2c_regs_top
    import i2c_regs_pkg::*;
(
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic        scl,
    inout  wire         sda,
    input  logic        rd_en,
    input  host_addr_t  host_addr,
    output logic [15:0] host_data
);

    line_events_t events;
    logic         start_rx;
    logic         start_tx;
    logic         nack_mode;
    logic         byte_done;
    logic         sda_pull;
    logic         req_valid;
    logic         req_ack;
    byte_t        tx_byte;
    byte_t        rx_byte;
    byte_t        rd_byte;
    reg_req_t     req;

    // open drain, never driven high
    assign sda = sda_pull ? 1'b0 : 1'bz;

    bus_sampler u_sampler (
        .CLOCK  (CLOCK),
        .RESET  (RESET),
        .scl    (scl),
        .sda_in (sda),
        .events (events)
    );

    byte_shifter u_shifter (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .events    (events),
        .start_rx  (start_rx),
        .start_tx  (start_tx),
        .tx_byte   (tx_byte),
        .nack_mode (nack_mode),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .sda_pull  (sda_pull)
    );

    transaction_ctrl u_ctrl (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .events    (events),
        .start_rx  (start_rx),
        .start_tx  (start_tx),
        .tx_byte   (tx_byte),
        .nack_mode (nack_mode),
        .rx_byte   (rx_byte),
        .byte_done (byte_done),
        .req_valid (req_valid),
        .req       (req),
        .req_ack   (req_ack),
        .rd_byte   (rd_byte)
    );

    reg_file u_regs (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .req_ack   (req_ack),
        .rd_byte   (rd_byte),
        .rd_en     (rd_en),
        .host_addr (host_addr),
        .host_data (host_data)
    );

endmodule

//--- verification/i2c_regs_chk.sv
// i2c register target protocol checks
module i2c_regs_chk
    import i2c_regs_pkg::*;
(
    input logic        CLOCK,
    input logic        RESET,
    input logic        scl,
    input logic        sda_pull,
    input logic        byte_done,
    input logic        req_valid,
    input reg_req_t    req,
    input logic        req_ack,
    input logic        rd_en,
    input host_addr_t  host_addr,
    input logic [15:0] host_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far
    int unsigned fail_count = 0;

    // target drive only moves while scl is low
    // master start and stop edges are outside sda_pull
    sda_steady: assert property (@(posedge CLOCK) disable iff (RESET)
        (scl && $past(scl)) |-> $stable(sda_pull))
    else
    begin
        $error("target changed its sda drive while scl was high");
        fail_count++;
    end

    // addresses 4..7 have no word
    host_zero: assert property (@(posedge CLOCK) disable iff (RESET)
        (rd_en && (host_addr >= 3'd4)) |=> (host_data == 16'h0000))
    else
    begin
        $error("host_data not zero after a read past word 3");
        fail_count++;
    end

    // ack follows valid by one cycle
    req_answered: assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(req_valid) |=> req_ack)
    else
    begin
        $error("req_ack missing one cycle after req_valid rose");
        fail_count++;
    end

    req_held: assert property (@(posedge CLOCK) disable iff (RESET)
        (req_valid && $past(req_valid)) |-> $stable(req))
    else
    begin
        $error("request changed while req_valid was high");
        fail_count++;
    end

    // everything quiet right out of reset
    reset_state: assert property (@(posedge CLOCK) disable iff (RESET)
        $fell(RESET) |-> (!sda_pull && !req_valid && !req_ack && !byte_done
                          && (host_data == 16'h0000)))
    else
    begin
        $error("outputs not inactive after reset");
        fail_count++;
    end

endmodule

//--- verification/i2c_regs_tb.sv
// i2c register target testbench
module i2c_regs_tb
    import i2c_regs_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // scl half period, longer than the debounce delay plus a register handshake
    localparam int half_period = 2 * debounce_len + 5;
    localparam int low_lead = half_period / 2;
    localparam int low_tail = half_period - low_lead;
    // longest transaction is a read, about 36 bits of 50 cycles plus conditions
    localparam int transaction_cycles = 2000;
    localparam int test_count = 12;
    localparam int timeout_cycles = test_count * transaction_cycles + 6000;
    localparam byte_t write_ctrl = {target_addr, 1'b0};
    localparam byte_t read_ctrl = {target_addr, 1'b1};

    logic        CLOCK;
    logic        RESET;
    logic        scl;
    logic        sda_low;
    wire         sda;
    logic        rd_en;
    host_addr_t  host_addr;
    logic [15:0] host_data;
    int          errors;
    int          cycle_count;
    integer      seed;
    byte_t       byte_a;
    byte_t       byte_b;
    byte_t       got;
    logic        acked;
    logic [15:0] word;

    // master side of the open-drain line
    assign sda = sda_low ? 1'b0 : 1'bz;
    pullup (sda);

    bind i2c_regs_top i2c_regs_chk protocol_chk (.*);

    i2c_regs_top uut (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .rd_en     (rd_en),
        .host_addr (host_addr),
        .host_data (host_data)
    );

    always #5 CLOCK = ~CLOCK;

    always @(posedge CLOCK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout, tests still running after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK);
    endtask

    // scl low on entry and on exit
    // sda moves in the middle of the low phase
    task automatic clock_bit(input logic b, output logic seen);
        wait_cycles(low_lead);
        sda_low <= ~b;
        wait_cycles(low_tail);
        scl <= 1'b1;
        wait_cycles(low_lead);
        // mid high phase, line settled
        seen = sda;
        wait_cycles(low_tail);
        scl <= 1'b0;
    endtask

    // from an idle bus
    task automatic start_condition();
        wait_cycles(half_period);
        sda_low <= 1'b1;
        wait_cycles(half_period);
        scl <= 1'b0;
    endtask

    task automatic restart_condition();
        wait_cycles(low_lead);
        sda_low <= 1'b0;
        wait_cycles(low_tail);
        scl <= 1'b1;
        wait_cycles(half_period);
        sda_low <= 1'b1;
        wait_cycles(half_period);
        scl <= 1'b0;
    endtask

    // leaves both lines high
    task automatic stop_condition();
        wait_cycles(low_lead);
        sda_low <= 1'b1;
        wait_cycles(low_tail);
        scl <= 1'b1;
        wait_cycles(half_period);
        sda_low <= 1'b0;
        wait_cycles(half_period);
    endtask

    // msb first, then the ack clock with sda released
    task automatic send_byte(input byte_t value, output logic ack_seen);
        logic seen;
        for (int i = 7; i >= 0; i--)
            clock_bit(value[i], seen);
        clock_bit(1'b1, seen);
        ack_seen = ~seen;
    endtask

    task automatic receive_byte(output byte_t value);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, seen);
            value[i] = seen;
        end
        // one byte only, so nack
        clock_bit(1'b1, seen);
    endtask

    task automatic expect_ack(input logic ack_seen, input string test, input string stage);
        assert (ack_seen)
        else
        begin
            errors++;
            $display("%s: the target did not acknowledge the %s byte", test, stage);
        end
    endtask

    task automatic compare_value(input string test, input logic [15:0] expected,
                                 input logic [15:0] actual);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("ERROR %s expected 0x%04h actual 0x%04h", test, expected, actual);
        end
    endtask

    task automatic i2c_write(input string test, input reg_ptr_t ptr, input byte_t data);
        logic ack_seen;
        start_condition();
        send_byte(write_ctrl, ack_seen);
        expect_ack(ack_seen, test, "control");
        send_byte(ptr, ack_seen);
        expect_ack(ack_seen, test, "pointer");
        send_byte(data, ack_seen);
        expect_ack(ack_seen, test, "data");
        stop_condition();
    endtask

    // pointer write, repeated start, one byte back
    task automatic i2c_read(input string test, input reg_ptr_t ptr, output byte_t value);
        logic ack_seen;
        start_condition();
        send_byte(write_ctrl, ack_seen);
        expect_ack(ack_seen, test, "control");
        send_byte(ptr, ack_seen);
        expect_ack(ack_seen, test, "pointer");
        restart_condition();
        send_byte(read_ctrl, ack_seen);
        expect_ack(ack_seen, test, "read control");
        receive_byte(value);
        stop_condition();
    endtask

    // data valid one cycle after the rd_en edge
    task automatic host_read(input host_addr_t addr, output logic [15:0] data);
        wait_cycles(1);
        rd_en     <= 1'b1;
        host_addr <= addr;
        wait_cycles(1);
        rd_en <= 1'b0;
        wait_cycles(1);
        data = host_data;
    endtask

    initial
    begin
        CLOCK       = 1'b0;
        RESET       = 1'b1;
        scl         = 1'b1;
        sda_low     = 1'b0;
        rd_en       = 1'b0;
        host_addr   = '0;
        errors      = 0;
        cycle_count = 0;
        seed        = 32'hd194;
        wait_cycles(3);
        RESET <= 1'b0;
        // filters start high, give them time anyway
        wait_cycles(2 * debounce_len);

        // reset words, then an address past the map
        host_read(3'd0, word);
        compare_value("reset word 0", 16'h8095, word);
        host_read(3'd1, word);
        compare_value("reset word 1", 16'h031D, word);
        host_read(3'd2, word);
        compare_value("reset word 2", 16'h0000, word);
        host_read(3'd3, word);
        compare_value("reset word 3", 16'h0000, word);
        host_read(3'd5, word);
        compare_value("host word 5", 16'h0000, word);

        byte_a = byte_t'($random(seed));
        byte_b = byte_t'($random(seed));

        // odd pointer is the low half, even the high half
        i2c_write("write low byte", 8'h03, byte_a);
        host_read(3'd1, word);
        compare_value("write low byte", {8'h03, byte_a}, word);
        i2c_write("write high byte", 8'h02, byte_b);
        host_read(3'd1, word);
        compare_value("write high byte", {byte_b, byte_a}, word);

        i2c_read("read low byte", 8'h03, got);
        compare_value("read low byte", {8'h00, byte_a}, {8'h00, got});
        i2c_read("read high byte", 8'h02, got);
        compare_value("read high byte", {8'h00, byte_b}, {8'h00, got});

        // read-only bytes step by 0x10
        for (int i = 0; i < 4; i++)
        begin
            i2c_read($sformatf("read-only 0x%02h", 8'h08 + i), reg_ptr_t'(8'h08 + i), got);
            compare_value($sformatf("read-only 0x%02h", 8'h08 + i), 16'((i + 1) * 16),
                          {8'h00, got});
        end
        i2c_read("unmapped pointer", 8'h20, got);
        compare_value("unmapped pointer", 16'h00FF, {8'h00, got});
        i2c_write("write read-only", 8'h09, byte_a);
        i2c_read("write read-only", 8'h09, got);
        compare_value("write read-only", 16'h0020, {8'h00, got});

        // address 0x29, rest of the write must be ignored
        start_condition();
        send_byte({7'h29, 1'b0}, acked);
        assert (!acked)
        else
        begin
            errors++;
            $display("wrong address: the target acknowledged a control byte for 0x29");
        end
        send_byte(8'h03, acked);
        send_byte(~byte_a, acked);
        stop_condition();
        host_read(3'd0, word);
        compare_value("wrong address word 0", 16'h8095, word);
        host_read(3'd1, word);
        compare_value("wrong address word 1", {byte_b, byte_a}, word);
        host_read(3'd2, word);
        compare_value("wrong address word 2", 16'h0000, word);
        host_read(3'd3, word);
        compare_value("wrong address word 3", 16'h0000, word);

        wait_cycles(half_period);
        $display("error count: %0d testbench, %0d assertion", errors,
                 uut.protocol_chk.fail_count);
        if (errors + uut.protocol_chk.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- i2c_regs.f
hdl/i2c_regs_pkg.sv
hdl/bus_sampler.sv
hdl/byte_shifter.sv
hdl/transaction_ctrl.sv
hdl/reg_file.sv
hdl/i2c_regs_top.sv
verification/i2c_regs_chk.sv
verification/i2c_regs_tb.sv

//--- Bender.yml
package:
  name: i2c_regs

sources:
  - hdl/i2c_regs_pkg.sv
  - hdl/bus_sampler.sv
  - hdl/byte_shifter.sv
  - hdl/transaction_ctrl.sv
  - hdl/reg_file.sv
  - hdl/i2c_regs_top.sv
  - target: simulation
    files:
      - verification/i2c_regs_chk.sv
      - verification/i2c_regs_tb.sv
